/* design/fir_pkg.sv */
`default_nettype none

package fir_pkg;

    // data width on the bus and in both RAMs
    parameter int word_width = 32;

    typedef logic [word_width-1:0] fir_word_t;

    // byte-lane write enables
    typedef logic [3:0] we_t;

    // control word fields, ap_start in bit 0
    typedef struct packed {
        logic [28:0] rsvd;
        logic        ap_idle;
        logic        ap_done;
        logic        ap_start;
    } ap_ctrl_s;

    // raw word for the bus, field view for decode
    typedef union packed {
        fir_word_t raw;
        ap_ctrl_s  f;
    } ap_ctrl_u;

    // register map
    localparam int unsigned ctrl_offset     = 32'h00;
    localparam int unsigned length_offset   = 32'h10;
    // tap k at tap_base_offset + 4k
    localparam int unsigned tap_base_offset = 32'h20;

    // tap read while a frame runs
    localparam fir_word_t busy_read_word = '1;

endpackage

`default_nettype wire

/* design/axil_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_regs #(
    parameter int addr_width = 12,
    parameter int tap_num    = 11
) (
    input  wire                            axis_clk,
    input  wire                            axis_rst_n,
    input  wire                            awvalid,
    input  wire [addr_width-1:0]           awaddr,
    input  wire                            wvalid,
    input  wire fir_pkg::fir_word_t        wdata,
    input  wire                            arvalid,
    input  wire [addr_width-1:0]           araddr,
    input  wire                            rready,
    input  wire fir_pkg::fir_word_t        tap_rdata,
    input  wire                            first_in,
    input  wire                            frame_done,
    output logic                           awready,
    output logic                           wready,
    output logic                           arready,
    output logic                           rvalid,
    output fir_pkg::fir_word_t             rdata,
    output logic                           reg_tap_req,
    output fir_pkg::we_t                   reg_tap_we,
    output logic [$clog2(tap_num)-1:0]     reg_tap_idx,
    output fir_pkg::fir_word_t             reg_tap_wdata,
    output logic                           start
);
    import fir_pkg::*;

    localparam int idx_width = $clog2(tap_num);

    localparam logic       w_idle = 1'b0;
    localparam logic       w_data = 1'b1;
    localparam logic [1:0] r_idle = 2'd0;
    localparam logic [1:0] r_addr = 2'd1;
    localparam logic [1:0] r_wait = 2'd2;
    localparam logic [1:0] r_data = 2'd3;

    logic                  wstate;
    logic [1:0]            rstate;
    logic [addr_width-1:0] waddr;
    logic [addr_width-1:0] raddr;
    // busy state sampled with the read address
    logic                  rd_busy;
    // one flag per tap plus a top bit for the length register
    logic [tap_num:0]      prog;
    logic                  all_set;
    ap_ctrl_u              ctrl;
    ap_ctrl_u              wr_ctrl;
    logic                  w_fire;
    logic                  start_ok;
    logic                  rd_req;

    function automatic logic in_tap(input logic [addr_width-1:0] a);
        in_tap = (a >= tap_base_offset) && (a < tap_base_offset + 4 * tap_num) &&
                 (a[1:0] == 2'b00);
    endfunction

    function automatic logic [idx_width-1:0] tap_idx(input logic [addr_width-1:0] a);
        logic [addr_width-1:0] off;
        off     = a - addr_width'(tap_base_offset);
        tap_idx = off[idx_width+1:2];
    endfunction

    // new writes only while idle
    assign awready = (wstate == w_idle) && ctrl.f.ap_idle;
    assign wready  = (wstate == w_data);
    assign arready = (rstate == r_addr);
    assign rvalid  = (rstate == r_data);
    assign w_fire  = wvalid && wready;
    assign all_set = &prog;

    // host view of a control write
    assign wr_ctrl.raw = wdata;
    assign start_ok    = w_fire && (waddr == ctrl_offset) && wr_ctrl.f.ap_start && all_set;
    // ap_start lives one cycle and doubles as the engine pulse
    assign start       = ctrl.f.ap_start;

    // reads wait behind a write in progress
    assign rd_req = arvalid && (rstate == r_idle) && (wstate == w_idle);

    // write commit and read address never share the tap port
    always_comb begin
        reg_tap_req   = 1'b0;
        reg_tap_we    = '0;
        reg_tap_idx   = tap_idx(araddr);
        reg_tap_wdata = wdata;
        if (w_fire && in_tap(waddr)) begin
            reg_tap_req = 1'b1;
            reg_tap_we  = '1;
            reg_tap_idx = tap_idx(waddr);
        end else if (rd_req && ctrl.f.ap_idle && in_tap(araddr)) begin
            reg_tap_req = 1'b1;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wstate <= w_idle;
        end else begin
            case (wstate)
                w_idle: if (awvalid && awready) wstate <= w_data;
                w_data: if (wvalid) wstate <= w_idle;
                default: wstate <= w_idle;
            endcase
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rstate  <= r_idle;
            rd_busy <= 1'b0;
        end else begin
            case (rstate)
                r_idle: begin
                    if (rd_req) begin
                        rstate  <= r_addr;
                        rd_busy <= !ctrl.f.ap_idle;
                    end
                end
                r_addr: rstate <= r_wait;
                // tap RAM output lands here
                r_wait: rstate <= r_data;
                r_data: if (rready) rstate <= r_idle;
                default: rstate <= r_idle;
            endcase
        end
    end

    // addresses and read data
    always_ff @(posedge axis_clk) begin
        if (awvalid && awready) waddr <= awaddr;
        if (rd_req) raddr <= araddr;
        if (rstate == r_wait) begin
            if (raddr == ctrl_offset) rdata <= ctrl.raw;
            else if (rd_busy) rdata <= busy_read_word;
            else if (in_tap(raddr)) rdata <= tap_rdata;
            else rdata <= '0;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ctrl.raw       <= '0;
            ctrl.f.ap_idle <= 1'b1;
            prog           <= '0;
        end else begin
            ctrl.f.ap_start <= start_ok;
            if (start_ok) ctrl.f.ap_idle <= 1'b0;
            if (first_in) ctrl.f.ap_done <= 1'b0;
            if (frame_done) begin
                ctrl.f.ap_done <= 1'b1;
                ctrl.f.ap_idle <= 1'b1;
            end
            // next frame must be programmed again
            if (frame_done) prog <= '0;
            else if (w_fire && waddr == length_offset) prog[tap_num] <= 1'b1;
            else if (w_fire && in_tap(waddr)) prog[tap_idx(waddr)] <= 1'b1;
        end
    end

    a_start_programmed: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        start |-> all_set);

    a_rvalid_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

/* design/tap_ram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module tap_ram_arbiter #(
    parameter int addr_width = 12,
    parameter int tap_num    = 11
) (
    input  wire                            axis_clk,
    input  wire                            axis_rst_n,
    input  wire                            reg_tap_req,
    input  wire fir_pkg::we_t              reg_tap_we,
    input  wire [$clog2(tap_num)-1:0]      reg_tap_idx,
    input  wire fir_pkg::fir_word_t        reg_tap_wdata,
    input  wire                            eng_tap_req,
    input  wire [$clog2(tap_num)-1:0]      eng_tap_idx,
    output logic [addr_width-1:0]          tap_A,
    output logic                           tap_EN,
    output fir_pkg::we_t                   tap_WE,
    output fir_pkg::fir_word_t             tap_Di
);
    import fir_pkg::*;

    logic [$clog2(tap_num)-1:0] sel_idx;

    // engine has priority
    assign sel_idx = eng_tap_req ? eng_tap_idx : reg_tap_idx;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            tap_EN <= 1'b0;
            tap_WE <= '0;
        end else begin
            tap_EN <= eng_tap_req || reg_tap_req;
            // engine only reads
            tap_WE <= (!eng_tap_req && reg_tap_req) ? reg_tap_we : we_t'(0);
        end
    end

    // word index to byte address
    always_ff @(posedge axis_clk) begin
        tap_A  <= addr_width'({sel_idx, 2'b00});
        tap_Di <= reg_tap_wdata;
    end

    // host side stays off the RAM while a frame runs
    a_no_overlap: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(reg_tap_req && eng_tap_req));

endmodule

`default_nettype wire

/* design/fir_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_engine #(
    parameter int addr_width = 12,
    parameter int tap_num    = 11
) (
    input  wire                            axis_clk,
    input  wire                            axis_rst_n,
    input  wire                            start,
    input  wire                            ss_tvalid,
    input  wire fir_pkg::fir_word_t        ss_tdata,
    input  wire                            ss_tlast,
    input  wire                            sm_tready,
    input  wire fir_pkg::fir_word_t        tap_Do,
    input  wire fir_pkg::fir_word_t        data_Do,
    output logic                           ss_tready,
    output logic                           sm_tvalid,
    output fir_pkg::fir_word_t             sm_tdata,
    output logic                           sm_tlast,
    output logic                           eng_tap_req,
    output logic [$clog2(tap_num)-1:0]     eng_tap_idx,
    output logic [addr_width-1:0]          data_A,
    output logic                           data_EN,
    output fir_pkg::we_t                   data_WE,
    output fir_pkg::fir_word_t             data_Di,
    output logic                           first_in,
    output logic                           frame_done
);
    import fir_pkg::*;

    localparam int idx_width = $clog2(tap_num);
    // counts issue cycles plus the two-cycle RAM latency
    localparam int cnt_width = $clog2(tap_num + 2);
    localparam logic [idx_width-1:0] last_idx = idx_width'(tap_num - 1);

    localparam logic [2:0] s_idle   = 3'd0;
    localparam logic [2:0] s_clear  = 3'd1;
    localparam logic [2:0] s_wait   = 3'd2;
    localparam logic [2:0] s_take   = 3'd3;
    localparam logic [2:0] s_settle = 3'd4;
    localparam logic [2:0] s_acc    = 3'd5;
    localparam logic [2:0] s_out    = 3'd6;

    logic [2:0]           state;
    logic [cnt_width-1:0] ctr;
    // ring pointers into the data RAM
    logic [idx_width-1:0] wptr;
    logic [idx_width-1:0] rptr;
    logic                 last_q;
    logic                 first_q;
    fir_word_t            sample_q;
    fir_word_t            acc;
    logic                 issuing;
    logic                 d_en;
    we_t                  d_we;
    logic [idx_width-1:0] d_idx;
    fir_word_t            d_di;

    assign issuing     = (state == s_acc) && (ctr < cnt_width'(tap_num));
    assign eng_tap_req = issuing;
    // tap k pairs with the sample k steps back
    assign eng_tap_idx = idx_width'(ctr);

    assign ss_tready  = (state == s_wait);
    assign sm_tvalid  = (state == s_out);
    assign sm_tdata   = acc;
    assign sm_tlast   = last_q;
    assign first_in   = (state == s_wait) && ss_tvalid && first_q;
    assign frame_done = (state == s_out) && sm_tready && last_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state   <= s_idle;
            ctr     <= '0;
            wptr    <= '0;
            rptr    <= '0;
            last_q  <= 1'b0;
            first_q <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        state   <= s_clear;
                        ctr     <= '0;
                        wptr    <= '0;
                        first_q <= 1'b1;
                    end
                end
                // zero the history, one word a cycle
                s_clear: begin
                    ctr <= ctr + 1'b1;
                    if (ctr == cnt_width'(tap_num - 1)) state <= s_wait;
                end
                s_wait: begin
                    if (ss_tvalid) begin
                        last_q  <= ss_tlast;
                        first_q <= 1'b0;
                        state   <= s_take;
                    end
                end
                // newest sample is read first
                s_take: begin
                    rptr  <= wptr;
                    wptr  <= (wptr == last_idx) ? '0 : wptr + 1'b1;
                    ctr   <= '0;
                    state <= s_settle;
                end
                s_settle: state <= s_acc;
                s_acc: begin
                    ctr <= ctr + 1'b1;
                    if (issuing) rptr <= (rptr == '0) ? last_idx : rptr - 1'b1;
                    if (ctr == cnt_width'(tap_num + 1)) state <= s_out;
                end
                // hold the result until the sink takes it
                s_out: if (sm_tready) state <= last_q ? s_idle : s_wait;
                default: state <= s_idle;
            endcase
        end
    end

    // data RAM request, registered below to match the tap path
    always_comb begin
        d_en  = 1'b0;
        d_we  = '0;
        d_idx = rptr;
        d_di  = sample_q;
        case (state)
            s_clear: begin
                d_en  = 1'b1;
                d_we  = '1;
                d_idx = idx_width'(ctr);
                d_di  = '0;
            end
            s_take: begin
                d_en  = 1'b1;
                d_we  = '1;
                d_idx = wptr;
            end
            s_acc: d_en = issuing;
            default: d_en = 1'b0;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_EN <= 1'b0;
            data_WE <= '0;
        end else begin
            data_EN <= d_en;
            data_WE <= d_we;
        end
    end

    always_ff @(posedge axis_clk) begin
        data_A  <= addr_width'({d_idx, 2'b00});
        data_Di <= d_di;
        if (ss_tvalid && ss_tready) sample_q <= ss_tdata;
        // products arrive two cycles after their request
        if (state == s_take) acc <= '0;
        else if (state == s_acc && ctr >= cnt_width'(2)) acc <= acc + tap_Do * data_Do;
    end

    a_out_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast));

endmodule

`default_nettype wire

/* design/fir_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_top #(
    parameter int addr_width = 12,
    parameter int tap_num    = 11
) (
    output wire                          awready,
    output wire                          wready,
    input  wire                          awvalid,
    input  wire [addr_width-1:0]         awaddr,
    input  wire                          wvalid,
    input  wire fir_pkg::fir_word_t      wdata,
    output wire                          arready,
    input  wire                          rready,
    input  wire                          arvalid,
    input  wire [addr_width-1:0]         araddr,
    output wire                          rvalid,
    output wire fir_pkg::fir_word_t      rdata,
    input  wire                          ss_tvalid,
    input  wire fir_pkg::fir_word_t      ss_tdata,
    input  wire                          ss_tlast,
    output wire                          ss_tready,
    input  wire                          sm_tready,
    output wire                          sm_tvalid,
    output wire fir_pkg::fir_word_t      sm_tdata,
    output wire                          sm_tlast,
    output wire fir_pkg::we_t            tap_WE,
    output wire                          tap_EN,
    output wire fir_pkg::fir_word_t      tap_Di,
    output wire [addr_width-1:0]         tap_A,
    input  wire fir_pkg::fir_word_t      tap_Do,
    output wire fir_pkg::we_t            data_WE,
    output wire                          data_EN,
    output wire fir_pkg::fir_word_t      data_Di,
    output wire [addr_width-1:0]         data_A,
    input  wire fir_pkg::fir_word_t      data_Do,
    input  wire                          axis_clk,
    input  wire                          axis_rst_n
);
    import fir_pkg::*;

    // host side of the tap RAM
    wire                        reg_tap_req;
    we_t                        reg_tap_we;
    wire [$clog2(tap_num)-1:0]  reg_tap_idx;
    fir_word_t                  reg_tap_wdata;
    // engine side of the tap RAM
    wire                        eng_tap_req;
    wire [$clog2(tap_num)-1:0]  eng_tap_idx;
    // frame handshake between register block and engine
    wire                        start;
    wire                        first_in;
    wire                        frame_done;

    axil_regs #(.addr_width(addr_width), .tap_num(tap_num)) u_regs (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
        .arvalid(arvalid), .araddr(araddr), .rready(rready), .tap_rdata(tap_Do),
        .first_in(first_in), .frame_done(frame_done),
        .awready(awready), .wready(wready), .arready(arready),
        .rvalid(rvalid), .rdata(rdata),
        .reg_tap_req(reg_tap_req), .reg_tap_we(reg_tap_we),
        .reg_tap_idx(reg_tap_idx), .reg_tap_wdata(reg_tap_wdata), .start(start)
    );

    tap_ram_arbiter #(.addr_width(addr_width), .tap_num(tap_num)) u_arb (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .reg_tap_req(reg_tap_req), .reg_tap_we(reg_tap_we),
        .reg_tap_idx(reg_tap_idx), .reg_tap_wdata(reg_tap_wdata),
        .eng_tap_req(eng_tap_req), .eng_tap_idx(eng_tap_idx),
        .tap_A(tap_A), .tap_EN(tap_EN), .tap_WE(tap_WE), .tap_Di(tap_Di)
    );

    fir_engine #(.addr_width(addr_width), .tap_num(tap_num)) u_engine (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n), .start(start),
        .ss_tvalid(ss_tvalid), .ss_tdata(ss_tdata), .ss_tlast(ss_tlast),
        .sm_tready(sm_tready), .tap_Do(tap_Do), .data_Do(data_Do),
        .ss_tready(ss_tready), .sm_tvalid(sm_tvalid), .sm_tdata(sm_tdata),
        .sm_tlast(sm_tlast), .eng_tap_req(eng_tap_req), .eng_tap_idx(eng_tap_idx),
        .data_A(data_A), .data_EN(data_EN), .data_WE(data_WE), .data_Di(data_Di),
        .first_in(first_in), .frame_done(frame_done)
    );

endmodule

`default_nettype wire

/* verif/bram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module bram_model #(
    parameter int addr_width = 12
) (
    input  wire                          axis_clk,
    input  wire fir_pkg::we_t            we,
    input  wire                          en,
    input  wire fir_pkg::fir_word_t      wr_data,
    input  wire [addr_width-1:0]         addr,
    output fir_pkg::fir_word_t           rd_data
);
    import fir_pkg::*;

    localparam int depth = 2 ** (addr_width - 2);

    fir_word_t mem [depth];

    // every word differs, so a stray read shows up
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = 32'hc3c3_0000 ^ fir_word_t'(i);
        end
    end

    // byte lanes, read returns the old word one cycle later
    always @(posedge axis_clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) mem[addr[addr_width-1:2]][8*b +: 8] <= wr_data[8*b +: 8];
            end
            rd_data <= mem[addr[addr_width-1:2]];
        end
    end

endmodule

`default_nettype wire

/* verif/tb_tasks.svh */
`ifndef tb_tasks_svh
`define tb_tasks_svh

// expected control word from its three flags
function automatic ap_ctrl_u make_ctrl(input logic idle, input logic done, input logic start);
    ap_ctrl_u c;
    c.raw        = '0;
    c.f.ap_idle  = idle;
    c.f.ap_done  = done;
    c.f.ap_start = start;
    return c;
endfunction

// truncated convolution over a zeroed history
function automatic fir_word_t golden_out(input int n);
    fir_word_t sum;
    int        k;
    sum = '0;
    for (k = 0; k < tap_num; k++) begin
        if (n - k >= 0) sum = sum + taps[k] * samples[n - k];
    end
    return sum;
endfunction

task automatic check_word(input string what, input fir_word_t exp, input fir_word_t act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("error in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
    end
endtask

task automatic check_ctrl(input string what, input ap_ctrl_u exp, input ap_ctrl_u act);
    checks++;
    if (exp.raw !== act.raw) begin
        errors++;
        $display("error in %s, %s: expected %h (idle %b done %b start %b), actual %h %s",
                 cur_test, what, exp.raw, exp.f.ap_idle, exp.f.ap_done, exp.f.ap_start,
                 act.raw, $sformatf("(idle %b done %b start %b)",
                                    act.f.ap_idle, act.f.ap_done, act.f.ap_start));
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("error in %s, %s: expected %b, actual %b", cur_test, what, exp, act);
    end
endtask

// anything that is not a plain value mismatch
task automatic note_failure(input string msg);
    errors++;
    $display("%s failed: %s", cur_test, msg);
endtask

task automatic begin_test(input string name);
    cur_test      = name;
    errors_before = errors;
    tests_run++;
endtask

task automatic end_test();
    if (errors == errors_before) begin
        $display("test %s: ok", cur_test);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", cur_test, errors - errors_before);
    end
endtask

// all bus tasks start and end on a falling edge
task automatic axil_write(input int unsigned offset, input fir_word_t data);
    awvalid = 1'b1;
    awaddr  = addr_width'(offset);
    while (!awready) @(negedge axis_clk);
    @(negedge axis_clk);
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    while (!wready) @(negedge axis_clk);
    @(negedge axis_clk);
    wvalid  = 1'b0;
endtask

// hold keeps rready low for that many cycles after rvalid
task automatic axil_read(input int unsigned offset, input int hold, output fir_word_t data);
    int lat;
    arvalid = 1'b1;
    araddr  = addr_width'(offset);
    while (!arready) @(negedge axis_clk);
    @(negedge axis_clk);
    arvalid = 1'b0;
    rready  = (hold == 0);
    lat     = 1;
    while (!rvalid) begin
        @(negedge axis_clk);
        lat++;
    end
    if (lat != 2) note_failure($sformatf("rvalid came %0d cycles after arready, not 2", lat));
    data = rdata;
    repeat (hold) begin
        @(negedge axis_clk);
        check_bit("rvalid held", 1'b1, rvalid);
        check_word("rdata held", data, rdata);
    end
    rready = 1'b1;
    @(negedge axis_clk);
    rready = 1'b0;
endtask

task automatic read_ctrl_expect(input string what, input ap_ctrl_u exp);
    fir_word_t rd;
    ap_ctrl_u  c;
    axil_read(ctrl_offset, 0, rd);
    c.raw = rd;
    check_ctrl(what, exp, c);
endtask

// length and fresh random taps
// a negative skip writes all of them
task automatic program_filter(input int skip);
    int k;
    axil_write(length_offset, fir_word_t'(frame_len));
    for (k = 0; k < tap_num; k++) begin
        taps[k] = $urandom;
        if (k != skip) axil_write(tap_base_offset + 4 * k, taps[k]);
    end
endtask

// one frame in and out with random sink stalls
task automatic run_stream();
    int        i;
    int        j;
    logic      held;
    fir_word_t held_data;
    for (i = 0; i < frame_len; i++) samples[i] = $urandom;
    got_data.delete();
    got_last.delete();
    fork
        begin
            for (i = 0; i < frame_len; i++) begin
                ss_tvalid = 1'b1;
                ss_tdata  = samples[i];
                ss_tlast  = (i == frame_len - 1);
                while (!ss_tready) @(negedge axis_clk);
                @(negedge axis_clk);
            end
            ss_tvalid = 1'b0;
            ss_tlast  = 1'b0;
        end
        begin
            held = 1'b0;
            while (got_data.size() < frame_len) begin
                @(negedge axis_clk);
                if (held && !sm_tvalid) note_failure("sm_tvalid dropped before sm_tready");
                else if (held) check_word("sm_tdata under back-pressure", held_data, sm_tdata);
                // no new sample while an output waits
                if (sm_tvalid) check_bit("ss_tready while output pending", 1'b0, ss_tready);
                sm_tready = ($urandom_range(3) != 0);
                held      = sm_tvalid && !sm_tready;
                held_data = sm_tdata;
                if (sm_tvalid && sm_tready) begin
                    got_data.push_back(sm_tdata);
                    got_last.push_back(sm_tlast);
                end
            end
            @(negedge axis_clk);
            sm_tready = 1'b0;
        end
    join
    for (j = 0; j < frame_len; j++) begin
        check_word($sformatf("output %0d", j), golden_out(j), got_data[j]);
        check_bit($sformatf("tlast of output %0d", j), j == frame_len - 1, got_last[j]);
    end
endtask

task automatic reset_values();
    begin_test("reset_values");
    check_bit("wready", 1'b0, wready);
    check_bit("arready", 1'b0, arready);
    check_bit("rvalid", 1'b0, rvalid);
    check_bit("ss_tready", 1'b0, ss_tready);
    check_bit("sm_tvalid", 1'b0, sm_tvalid);
    check_bit("tap_EN", 1'b0, tap_EN);
    check_bit("tap_WE", 1'b0, |tap_WE);
    check_bit("data_WE", 1'b0, |data_WE);
    read_ctrl_expect("control word", make_ctrl(1'b1, 1'b0, 1'b0));
    end_test();
endtask

task automatic tap_readback();
    int        k;
    fir_word_t rd;
    begin_test("tap_readback");
    for (k = 0; k < tap_num; k++) begin
        taps[k] = $urandom;
        axil_write(tap_base_offset + 4 * k, taps[k]);
    end
    // first read also holds rready low for a while
    for (k = 0; k < tap_num; k++) begin
        axil_read(tap_base_offset + 4 * k, (k == 0) ? 3 : 0, rd);
        check_word($sformatf("tap %0d", k), taps[k], rd);
    end
    end_test();
endtask

task automatic refused_start();
    begin_test("refused_start");
    apply_reset();
    program_filter(tap_num - 1);
    axil_write(ctrl_offset, 32'h1);
    read_ctrl_expect("control word", make_ctrl(1'b1, 1'b0, 1'b0));
    repeat (tap_num + 4) @(negedge axis_clk);
    check_bit("ss_tready", 1'b0, ss_tready);
    end_test();
endtask

task automatic frame_with_backpressure();
    begin_test("frame_with_backpressure");
    program_filter(-1);
    axil_write(ctrl_offset, 32'h1);
    run_stream();
    read_ctrl_expect("control word after frame", make_ctrl(1'b1, 1'b1, 1'b0));
    end_test();
endtask

task automatic busy_read_and_refill();
    fir_word_t rd;
    begin_test("busy_read_and_refill");
    program_filter(-1);
    axil_write(ctrl_offset, 32'h1);
    // no write address accepted while the frame runs
    check_bit("awready while busy", 1'b0, awready);
    // done stays set until the first sample
    read_ctrl_expect("control word in frame", make_ctrl(1'b0, 1'b1, 1'b0));
    axil_read(tap_base_offset + 8, 0, rd);
    check_word("tap read while busy", 32'hffff_ffff, rd);
    run_stream();
    read_ctrl_expect("control word after frame", make_ctrl(1'b1, 1'b1, 1'b0));
    check_bit("awready after frame", 1'b1, awready);
    axil_read(tap_base_offset + 8, 0, rd);
    check_word("tap 2 after frame", taps[2], rd);
    end_test();
endtask

`endif

/* verif/tb_fir.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fir;
    import fir_pkg::*;

    localparam int addr_width = 12;
    localparam int tap_num    = 11;
    localparam int frame_len  = 16;
    // sink holds tready low about one cycle in four
    localparam int max_gap    = 3;
    // take, settle, tap_num+2 accumulate, output, stream handshakes
    localparam int sample_cycles = tap_num + 6 + max_gap;
    // one bus access including a short rdata hold
    localparam int access_cycles = 10;
    // two frames plus four rounds of tap writes and reads, with a factor of four
    localparam int cycle_limit = 4 * (2 * frame_len * sample_cycles
                                      + 4 * 2 * (tap_num + 2) * access_cycles);

    // DUT inputs
    logic                  axis_clk;
    logic                  axis_rst_n;
    logic                  awvalid, wvalid, arvalid, rready;
    logic [addr_width-1:0] awaddr, araddr;
    fir_word_t             wdata, ss_tdata;
    logic                  ss_tvalid, ss_tlast, sm_tready;

    // DUT outputs
    wire                   awready, wready, arready, rvalid;
    wire                   ss_tready, sm_tvalid, sm_tlast;
    wire fir_word_t        rdata, sm_tdata;
    // RAM ports
    wire we_t              tap_WE, data_WE;
    wire                   tap_EN, data_EN;
    wire fir_word_t        tap_Di, data_Di, tap_Do, data_Do;
    wire [addr_width-1:0]  tap_A, data_A;

    // golden model inputs and captured outputs
    fir_word_t             taps [tap_num];
    fir_word_t             samples [frame_len];
    fir_word_t             got_data [$];
    logic                  got_last [$];

    int                    errors = 0;
    int                    checks = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    int                    errors_before = 0;
    int                    cycle_count = 0;
    string                 cur_test;

    fir_top #(.addr_width(addr_width), .tap_num(tap_num)) UUT (.*);

    bram_model #(.addr_width(addr_width)) tap_ram (
        .axis_clk(axis_clk), .we(tap_WE), .en(tap_EN),
        .wr_data(tap_Di), .addr(tap_A), .rd_data(tap_Do)
    );

    bram_model #(.addr_width(addr_width)) data_ram (
        .axis_clk(axis_clk), .we(data_WE), .en(data_EN),
        .wr_data(data_Di), .addr(data_A), .rd_data(data_Do)
    );

    initial axis_clk = 1'b0;
    always #20 axis_clk = ~axis_clk;

    // watchdog
    always @(posedge axis_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run stopped after %0d cycles, a test kept waiting on the DUT", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // two clock cycles, released on a falling edge
    task automatic apply_reset();
        axis_rst_n = 1'b0;
        repeat (2) @(negedge axis_clk);
        axis_rst_n = 1'b1;
    endtask

    `include "tb_tasks.svh"

    initial begin
        void'($urandom(32'hdf25278a));
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        ss_tlast  = 1'b0;
        sm_tready = 1'b0;
        apply_reset();
        reset_values();
        tap_readback();
        refused_start();
        frame_with_backpressure();
        busy_read_and_refill();
        $display("closing: %0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verif
design/fir_pkg.sv
design/axil_regs.sv
design/tap_ram_arbiter.sv
design/fir_engine.sv
design/fir_top.sv
verif/bram_model.sv
verif/tb_fir.sv

/* run.sh */
#!/bin/sh
# build and run the FIR testbench, pass only if the pass line is printed
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_fir -o tb_fir \
    && ./obj_dir/tb_fir | tee /dev/stderr | grep -qx "Test passed" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }
